// ==== sim/cmd_testdata.txt ====
# name ch len b0 b1 b2 b3 b4 b5 b6 b7 reply expected mask thr lower upper preoffset
# all hex; reply and thr are flags, lower upper preoffset are checked only when thr is 1
version 0 0 02 00 00 00 00 00 00 00 1 00000020 ffffffff 0 0 0 0
minor 0 0 0c 00 00 00 00 00 00 00 1 00000001 ffffffff 0 0 0 0
sub_unknown 0 0 02 07 00 00 00 00 00 00 1 00000000 ffffffff 0 0 0 0
ovr1_first 1 64 02 02 01 00 00 00 00 00 1 00000064 ffffffff 0 0 0 0
ovr1_second 1 20 02 02 01 00 00 00 00 00 1 00000084 ffffffff 0 0 0 0
ovr3_pulse 3 5 02 02 03 00 00 00 00 00 1 00000005 ffffffff 0 0 0 0
ovr0_idle 0 0 02 02 00 00 00 00 00 00 1 00000000 ffffffff 0 0 0 0
ovr2_idle 0 0 02 02 02 00 00 00 00 00 1 00000000 ffffffff 0 0 0 0
ovr1_after 0 0 02 02 01 00 00 00 00 00 1 00000084 ffffffff 0 0 0 0
trig_runt 0 0 08 90 10 01 23 05 01 08 1 00000008 ffffffff 1 f88008 288208 123
trig_norunt 0 0 08 80 20 03 ff 00 00 90 1 00000008 ffffffff 1 800e08 7ff208 3ff
bout_set1 0 0 0a 01 01 00 00 00 00 00 1 00000000 fffffff7 0 0 0 0
bout_set5 0 0 0a 05 01 00 00 00 00 00 1 00000002 fffffff7 0 0 0 0
bout_clr1 0 0 0a 01 00 00 00 00 00 00 1 00000022 fffffff7 0 0 0 0
bout_clr0 0 0 0a 00 00 00 00 00 00 00 1 00000020 fffffff7 0 0 0 0
boardin 0 0 02 01 00 00 00 00 00 00 1 000000a5 ffffffff 0 0 0 0
unknown_cmd 0 0 05 00 00 00 00 00 00 00 0 00000000 00000000 0 0 0 0
after_unknown 0 0 0c 00 00 00 00 00 00 00 1 00000001 ffffffff 0 0 0 0

// ==== project.f ====
+incdir+design
design/scope_cmd_pkg.sv
design/status_sync.sv
design/overrange_counter.sv
design/cmd_receiver.sv
design/cmd_executor.sv
design/usb_responder.sv
design/command_processor_top.sv
sim/command_processor_asserts.sv
sim/tb_command_processor.sv

// ==== sim/tb_command_processor.sv ====
// run from the project root; reads sim/cmd_testdata.txt, board inputs held at 8'ha5
`timescale 1ns/100ps
`include "scope_cmd_defines.svh"

module tb_command_processor;

   localparam int MAX_TESTS = 32;
   localparam int F_REPLY   = 10;   // field index of the reply flag
   localparam int F_THR     = 13;

   logic                   clk50;
   logic                   pllreset2;
   logic                   i_tvalid;
   logic [7:0]             i_tdata;
   logic                   o_tready_in;
   logic                   o_tvalid;
   logic [31:0]            o_tdata;
   logic [3:0]             o_tkeep;
   logic                   o_tlast;
   logic                   i_tready_out;
   logic [`SC_NUM_OVR-1:0] i_overrange;
   logic [7:0]             i_boardin;
   logic [7:0]             o_boardout;
   logic [23:0]            o_lowerthresh;
   logic [23:0]            o_upperthresh;
   logic [9:0]             o_ram_preoffset;
   logic [7:0]             o_trigger_tot;
   logic                   o_trigger_chan;

   string       t_name [MAX_TESTS];
   logic [31:0] fld [MAX_TESTS][17];   // ch, len, bytes 0..7, reply, exp, mask, thr, lo, up, pre
   int          n_tests  = 0;
   int          n_checks = 0;
   int          n_errors = 0;
   logic        loaded   = 1'b0;
   int unsigned cycle    = 0;

   command_processor_top i_command_processor_top (.*);

   initial begin
      clk50 = 1'b0;
      forever #20 clk50 = ~clk50;
   end

   always @(posedge clk50) begin
      cycle <= cycle + 1;
   end

   task automatic check_value(input string name, input string what,
                              input logic [31:0] expv, input logic [31:0] actv);
      n_checks++;
      assert (actv === expv) else begin
         $display("ERROR %s: %s expected %h, actual %h", name, what, expv, actv);
         n_errors++;
      end
   endtask

   task automatic report_failure(input string text);
      $display("%s", text);
      n_errors++;
   endtask

   // enters and leaves on a falling edge
   task automatic send_byte(input logic [7:0] b);
      i_tdata  = b;
      i_tvalid = 1'b1;
      while (!o_tready_in) begin
         @(negedge clk50);
      end
      @(negedge clk50);   // taken on the rising edge just passed
      i_tvalid = 1'b0;
   endtask

   task automatic pulse_overrange(input int ch, input int len);
      if (len > 0) begin
         i_overrange[ch] = 1'b1;
         repeat (len) @(negedge clk50);
         i_overrange[ch] = 1'b0;
         repeat (4) @(negedge clk50);   // synchronizer drains
      end
   endtask

   task automatic take_reply(input string name, output logic [31:0] data, output logic got);
      int wait_cnt;
      int hold;
      wait_cnt = 0;
      hold     = $urandom % 8;
      got      = 1'b0;
      data     = '0;
      while (!o_tvalid && wait_cnt < 1000) begin
         @(negedge clk50);
         wait_cnt++;
      end
      if (o_tvalid) begin
         repeat (hold) @(negedge clk50);   // back-pressure before the beat
         data = o_tdata;
         check_value(name, "tkeep", 32'hf, o_tkeep);
         i_tready_out = 1'b1;
         @(negedge clk50);
         i_tready_out = 1'b0;
         got          = 1'b1;
      end else begin
         report_failure({"no reply beat arrived for test ", name});
      end
   endtask

   task automatic run_test(input int t);
      logic [31:0] data;
      logic        got;
      int          seen;
      pulse_overrange(fld[t][0], fld[t][1]);
      for (int i = 2; i < 10; i++) begin
         send_byte(fld[t][i][7:0]);
      end
      if (fld[t][F_REPLY] != 0) begin
         take_reply(t_name[t], data, got);
         if (got) begin
            check_value(t_name[t], "reply", fld[t][11] & fld[t][12], data & fld[t][12]);
         end
      end else begin
         seen = 0;
         repeat (200) begin
            @(negedge clk50);
            if (o_tvalid) begin
               seen++;
            end
         end
         check_value(t_name[t], "beats in 200 cycles", 32'd0, seen);
      end
      if (fld[t][F_THR] != 0) begin
         check_value(t_name[t], "lower threshold", fld[t][14], o_lowerthresh);
         check_value(t_name[t], "upper threshold", fld[t][15], o_upperthresh);
         check_value(t_name[t], "ram pre-offset", fld[t][16], o_ram_preoffset);
         check_value(t_name[t], "trigger tot", fld[t][7] & 32'hff, o_trigger_tot);   // byte 5
         check_value(t_name[t], "trigger channel", fld[t][8] & 32'd1, o_trigger_chan);
      end
   endtask

   initial begin
      int    fd;
      int    rc;
      string line;
      int    t0;
      logic  prev;
      void'($urandom(32'h9639));
      pllreset2    = 1'b1;
      i_tvalid     = 1'b0;
      i_tdata      = '0;
      i_tready_out = 1'b0;
      i_overrange  = '0;
      i_boardin    = 8'ha5;
      fd = $fopen("sim/cmd_testdata.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open the test data file sim/cmd_testdata.txt");
      end else begin
         while (!$feof(fd) && n_tests < MAX_TESTS) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line[0] != "#") begin
               rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  t_name[n_tests], fld[n_tests][0], fld[n_tests][1], fld[n_tests][2],
                  fld[n_tests][3], fld[n_tests][4], fld[n_tests][5], fld[n_tests][6],
                  fld[n_tests][7], fld[n_tests][8], fld[n_tests][9], fld[n_tests][10],
                  fld[n_tests][11], fld[n_tests][12], fld[n_tests][13], fld[n_tests][14],
                  fld[n_tests][15], fld[n_tests][16]);
               if (rc == 18) begin
                  n_tests++;
               end
            end
         end
         $fclose(fd);
      end
      loaded = 1'b1;
      repeat (16) @(posedge clk50);
      @(negedge clk50);
      pllreset2 = 1'b0;
      repeat (2) @(negedge clk50);
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      // probe wave on bit 3 measured between two toggles
      prev = o_boardout[3];
      while (o_boardout[3] == prev) begin
         @(negedge clk50);
      end
      t0   = cycle;
      prev = o_boardout[3];
      while (o_boardout[3] == prev) begin
         @(negedge clk50);
      end
      check_value("probe", "toggle spacing", `SC_PROBE_HALF + 1, cycle - t0);
      $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors,
               i_command_processor_top.i_usb_responder.i_asserts.fail_cnt);
      if (n_errors == 0 && i_command_processor_top.i_usb_responder.i_asserts.fail_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog sized from the number of tests plus the probe measurement
   initial begin
      wait (loaded);
      repeat (n_tests * 2000 + 60000 + 16) @(posedge clk50);
      $display("timeout: run did not end within %0d cycles", n_tests * 2000 + 60000 + 16);
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== sim/command_processor_asserts.sv ====
// checks the usb output beat protocol of usb_responder; failures also raise fail_cnt
`timescale 1ns/100ps

module command_processor_asserts (
   input logic        clk50,
   input logic        pllreset2,
   input logic        o_tvalid,
   input logic [31:0] o_tdata,
   input logic        o_tlast,
   input logic        i_tready_out
);

   int fail_cnt = 0;

   // a waiting beat keeps valid and data
   a_hold: assert property (@(posedge clk50) disable iff (pllreset2)
      (o_tvalid && !i_tready_out) |=> (o_tvalid && $stable(o_tdata)))
      else begin
         $error("reply beat changed or vanished before it was accepted");
         fail_cnt++;
      end

   a_last: assert property (@(posedge clk50) disable iff (pllreset2)
      o_tvalid |-> o_tlast)   // every reply is a single beat
      else begin
         $error("tlast low on a valid beat");
         fail_cnt++;
      end

   a_reset: assert property (@(posedge clk50) pllreset2 |=> !o_tvalid)
      else begin
         $error("tvalid high right after reset");
         fail_cnt++;
      end

endmodule

bind usb_responder command_processor_asserts i_asserts (
   .clk50        (clk50),
   .pllreset2    (pllreset2),
   .o_tvalid     (o_tvalid),
   .o_tdata      (o_tdata),
   .o_tlast      (o_tlast),
   .i_tready_out (i_tready_out)
);

// ==== design/command_processor_top.sv ====
// single clk50 domain with synchronous pllreset2; status pins may be asynchronous
`timescale 1ns/100ps
`include "scope_cmd_defines.svh"

module command_processor_top
   import scope_cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   // usb byte stream in
   input  logic       i_tvalid,
   input  cmd_byte_t  i_tdata,
   output logic       o_tready_in,
   // usb word stream out
   output logic       o_tvalid,
   output resp_word_t o_tdata,
   output logic [3:0] o_tkeep,
   output logic       o_tlast,
   input  logic       i_tready_out,
   // board side
   input  ovr_flags_t i_overrange,
   input  board_t     i_boardin,
   output board_t     o_boardout,
   output thresh_t    o_lowerthresh,
   output thresh_t    o_upperthresh,
   output preoffset_t o_ram_preoffset,
   output cmd_byte_t  o_trigger_tot,
   output logic       o_trigger_chan
);

   ovr_flags_t                   ovr_sync;
   board_t                       board_sync;
   ovr_count_t [`SC_NUM_OVR-1:0] ovr_count;
   cmd_byte_t  [7:0]             cmd_bytes;
   logic                         cmd_strobe;
   resp_word_t                   resp_word;
   logic                         resp_strobe;
   logic                         resp_silent;
   logic                         done;   // reply finished

   status_sync i_status_sync (
      .clk50        (clk50),
      .pllreset2    (pllreset2),
      .i_overrange  (i_overrange),
      .i_boardin    (i_boardin),
      .o_ovr_sync   (ovr_sync),
      .o_board_sync (board_sync)
   );

   for (genvar k = 0; k < `SC_NUM_OVR; k++) begin : g_ovr
      overrange_counter i_overrange_counter (
         .clk50     (clk50),
         .pllreset2 (pllreset2),
         .i_flag    (ovr_sync[k]),
         .o_count   (ovr_count[k])
      );
   end

   cmd_receiver i_cmd_receiver (
      .clk50        (clk50),
      .pllreset2    (pllreset2),
      .i_tvalid     (i_tvalid),
      .i_tdata      (i_tdata),
      .i_done       (done),
      .o_tready_in  (o_tready_in),
      .o_cmd_bytes  (cmd_bytes),
      .o_cmd_strobe (cmd_strobe)
   );

   cmd_executor i_cmd_executor (
      .clk50           (clk50),
      .pllreset2       (pllreset2),
      .i_cmd_bytes     (cmd_bytes),
      .i_cmd_strobe    (cmd_strobe),
      .i_ovr_count     (ovr_count),
      .i_board_sync    (board_sync),
      .o_resp_word     (resp_word),
      .o_resp_strobe   (resp_strobe),
      .o_resp_silent   (resp_silent),
      .o_lowerthresh   (o_lowerthresh),
      .o_upperthresh   (o_upperthresh),
      .o_ram_preoffset (o_ram_preoffset),
      .o_trigger_tot   (o_trigger_tot),
      .o_trigger_chan  (o_trigger_chan),
      .o_boardout      (o_boardout)
   );

   usb_responder i_usb_responder (
      .clk50         (clk50),
      .pllreset2     (pllreset2),
      .i_resp_word   (resp_word),
      .i_resp_strobe (resp_strobe),
      .i_resp_silent (resp_silent),
      .i_tready_out  (i_tready_out),
      .o_tvalid      (o_tvalid),
      .o_tdata       (o_tdata),
      .o_tkeep       (o_tkeep),
      .o_tlast       (o_tlast),
      .o_done        (done)
   );

endmodule

// ==== design/usb_responder.sv ====
// one full 32-bit beat per reply; waits for i_tready_out without any timeout
`timescale 1ns/100ps

module usb_responder
   import scope_cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   input  resp_word_t i_resp_word,
   input  logic       i_resp_strobe,
   input  logic       i_resp_silent,
   input  logic       i_tready_out,
   output logic       o_tvalid,
   output resp_word_t o_tdata,
   output logic [3:0] o_tkeep,
   output logic       o_tlast,
   output logic       o_done
);

   tx_state_t state;

   assign o_tvalid = (state == TX_SEND);
   assign o_tkeep  = 4'b1111;   // every beat is a full word
   assign o_tlast  = 1'b1;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state  <= TX_IDLE;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         case (state)
            TX_IDLE: begin
               if (i_resp_strobe) begin
                  if (i_resp_silent) begin
                     o_done <= 1'b1;   // nothing to send
                  end else begin
                     state <= TX_SEND;
                  end
               end
            end
            TX_SEND: begin
               if (i_tready_out) begin
                  state  <= TX_IDLE;
                  o_done <= 1'b1;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk50) begin
      if (i_resp_strobe && (state == TX_IDLE)) begin
         o_tdata <= i_resp_word;   // held until accepted
      end
   end

endmodule

// ==== design/cmd_executor.sv ====
// thresholds wrap in 12 bits; counter select uses byte 2 bits 1:0 so four channels are assumed
`timescale 1ns/100ps
`include "scope_cmd_defines.svh"

module cmd_executor
   import scope_cmd_pkg::*;
(
   input  logic                         clk50,
   input  logic                         pllreset2,
   input  cmd_byte_t [7:0]              i_cmd_bytes,
   input  logic                         i_cmd_strobe,
   input  ovr_count_t [`SC_NUM_OVR-1:0] i_ovr_count,
   input  board_t                       i_board_sync,
   output resp_word_t                   o_resp_word,
   output logic                         o_resp_strobe,
   output logic                         o_resp_silent,
   output thresh_t                      o_lowerthresh,
   output thresh_t                      o_upperthresh,
   output preoffset_t                   o_ram_preoffset,
   output cmd_byte_t                    o_trigger_tot,
   output logic                         o_trigger_chan,
   output board_t                       o_boardout
);

   logic [11:0] b1;   // command bytes widened to 12 bits
   logic [11:0] b2;
   logic [11:0] b7;
   logic [11:0] lo_main;
   logic [11:0] up_main;
   logic [11:0] lo_runt;
   logic [11:0] up_runt;
   logic        runt_off;
   logic        known_cmd;
   resp_word_t  resp_next;
   logic [15:0] probe_cnt;   // probe compensation divider

   // trigger levels, in adc counts scaled by 16
   always_comb begin
      b1       = {4'd0, i_cmd_bytes[1]};
      b2       = {4'd0, i_cmd_bytes[2]};
      b7       = {4'd0, i_cmd_bytes[7]};
      runt_off = (i_cmd_bytes[7] >= 8'(`SC_RUNT_OFF));
      lo_main  = ((b1 - b2 - 12'(`SC_THR_MID)) << 4) + 12'd8;   // centre of the code bin
      up_main  = ((b1 + b2 - 12'(`SC_THR_MID)) << 4) + 12'd8;
      if (runt_off) begin
         lo_runt = 12'h800;   // -2048
         up_runt = 12'h7ff;   // 2047
      end else begin
         lo_runt = ((b1 - b2 - b7 - 12'(`SC_THR_MID)) << 4) + 12'd8;
         up_runt = ((b1 + b2 + b7 - 12'(`SC_THR_MID)) << 4) + 12'd8;
      end
   end

   // reply word for the command in hand
   always_comb begin
      known_cmd = 1'b1;
      resp_next = '0;
      case (i_cmd_bytes[0])
         `SC_CMD_STATUS: begin
            case (i_cmd_bytes[1])
               `SC_SUB_VERSION: resp_next = resp_word_t'(`SC_VERSION);
               `SC_SUB_BOARDIN: resp_next = {24'd0, i_board_sync};
               `SC_SUB_OVR:     resp_next = i_ovr_count[i_cmd_bytes[2][1:0]];
               default:         resp_next = '0;   // unknown subcommand still answers
            endcase
         end
         `SC_CMD_TRIG:     resp_next = resp_word_t'(`SC_CMD_TRIG);
         `SC_CMD_BOARDOUT: resp_next = {24'd0, o_boardout};   // value before the write
         `SC_CMD_MINOR:    resp_next = resp_word_t'(`SC_VERSION_MINOR);
         default:          known_cmd = 1'b0;   // dropped without a beat
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_resp_strobe   <= 1'b0;
         o_resp_silent   <= 1'b0;
         o_lowerthresh   <= '0;
         o_upperthresh   <= '0;
         o_ram_preoffset <= '0;
         o_trigger_tot   <= '0;
         o_trigger_chan  <= 1'b0;
         o_boardout      <= '0;
         probe_cnt       <= '0;
      end else begin
         o_resp_strobe <= i_cmd_strobe;
         o_resp_silent <= i_cmd_strobe & ~known_cmd;
         if (i_cmd_strobe) begin
            case (i_cmd_bytes[0])
               `SC_CMD_TRIG: begin
                  o_lowerthresh   <= {lo_runt, lo_main};
                  o_upperthresh   <= {up_runt, up_main};
                  o_ram_preoffset <= {i_cmd_bytes[3][1:0], i_cmd_bytes[4]};   // x256 plus byte 4
                  o_trigger_tot   <= i_cmd_bytes[5];
                  o_trigger_chan  <= i_cmd_bytes[6][0];
               end
               `SC_CMD_BOARDOUT: begin
                  o_boardout[i_cmd_bytes[1][2:0]] <= i_cmd_bytes[2][0];
               end
            endcase
         end
         // 1 kHz square wave on bit 3 overrides a command write in the same cycle
         if (probe_cnt == 16'(`SC_PROBE_HALF)) begin
            probe_cnt     <= '0;
            o_boardout[3] <= ~o_boardout[3];
         end else begin
            probe_cnt <= probe_cnt + 16'd1;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (i_cmd_strobe) begin
         o_resp_word <= resp_next;
      end
   end

endmodule

// ==== design/cmd_receiver.sv ====
// takes exactly eight bytes per command and stalls the usb input until the reply is done
`timescale 1ns/100ps

module cmd_receiver
   import scope_cmd_pkg::*;
(
   input  logic            clk50,
   input  logic            pllreset2,
   input  logic            i_tvalid,
   input  cmd_byte_t       i_tdata,
   input  logic            i_done,
   output logic            o_tready_in,
   output cmd_byte_t [7:0] o_cmd_bytes,
   output logic            o_cmd_strobe
);

   rx_state_t  state;
   logic [2:0] byte_idx;   // next byte slot
   logic       take;

   assign o_tready_in = (state == RX_COLLECT);
   assign take        = i_tvalid & o_tready_in;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state        <= RX_COLLECT;
         byte_idx     <= 3'd0;
         o_cmd_strobe <= 1'b0;
      end else begin
         o_cmd_strobe <= 1'b0;
         case (state)
            RX_COLLECT: begin
               if (take) begin
                  byte_idx <= byte_idx + 3'd1;   // wraps back to slot 0
                  if (byte_idx == 3'd7) begin
                     state        <= RX_WAIT;
                     o_cmd_strobe <= 1'b1;
                  end
               end
            end
            RX_WAIT: begin
               if (i_done) begin
                  state <= RX_COLLECT;   // reply sent or dropped
               end
            end
            default: begin
               state <= RX_COLLECT;
            end
         endcase
      end
   end

   // command bytes, stored by index
   always_ff @(posedge clk50) begin
      if (take) begin
         o_cmd_bytes[byte_idx] <= i_tdata;
      end
   end

endmodule

// ==== design/overrange_counter.sv ====
// counts clk50 cycles with the flag high; wraps at 2^32 and clears only on reset
`timescale 1ns/100ps

module overrange_counter
   import scope_cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   input  logic       i_flag,
   output ovr_count_t o_count
);

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_count <= '0;
      end else if (i_flag) begin
         o_count <= o_count + 32'd1;   // wraps
      end
   end

endmodule

// ==== design/status_sync.sv ====
// pins are taken as fully asynchronous; board bits may settle one cycle apart from each other
`timescale 1ns/100ps
`include "scope_cmd_defines.svh"

module status_sync
   import scope_cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   input  ovr_flags_t i_overrange,
   input  board_t     i_boardin,
   output ovr_flags_t o_ovr_sync,
   output board_t     o_board_sync
);

   ovr_flags_t ovr_meta;   // first stage
   board_t     board_meta;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         ovr_meta     <= '0;
         o_ovr_sync   <= '0;
         board_meta   <= '0;
         o_board_sync <= '0;
      end else begin
         ovr_meta     <= i_overrange;
         o_ovr_sync   <= ovr_meta;    // one bit per counter
         board_meta   <= i_boardin;
         o_board_sync <= board_meta;
      end
   end

endmodule

// ==== design/scope_cmd_pkg.sv ====
// shared types of the command path; widths are fixed except the over-range flag vector
`include "scope_cmd_defines.svh"

package scope_cmd_pkg;

   typedef logic [7:0]  cmd_byte_t;    // one usb command byte
   typedef logic [31:0] resp_word_t;   // one usb reply beat
   typedef logic [31:0] ovr_count_t;   // wraps silently

   // main threshold in the low half and runt threshold in the high half
   typedef logic [23:0] thresh_t;

   typedef logic [9:0]  preoffset_t;   // ram samples before trigger
   typedef logic [7:0]  board_t;

   typedef logic [`SC_NUM_OVR-1:0] ovr_flags_t;

   typedef enum logic {
      RX_COLLECT,
      RX_WAIT
   } rx_state_t;

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

endpackage

// ==== design/scope_cmd_defines.svh ====
// values assume clk50 at 50 MHz and exactly four over-range channels
`ifndef SCOPE_CMD_DEFINES_SVH
`define SCOPE_CMD_DEFINES_SVH

`define SC_NUM_OVR        4       // over-range inputs, one counter each

`define SC_VERSION        32      // major firmware version
`define SC_VERSION_MINOR  1

`define SC_PROBE_HALF     25000   // half period of the 1 kHz probe wave

// command codes in byte 0
`define SC_CMD_STATUS     2
`define SC_CMD_TRIG       8
`define SC_CMD_BOARDOUT   10
`define SC_CMD_MINOR      12

// status subcommands in byte 1
`define SC_SUB_VERSION    0
`define SC_SUB_BOARDIN    1
`define SC_SUB_OVR        2

`define SC_THR_MID        128     // adc mid-code
`define SC_RUNT_OFF       128     // byte 7 at or above this disables runt

`endif
